//--- rename_top.f
source/cpu_pkg.sv
source/id_itf.sv
source/decoder.sv
source/id_stage.sv
source/rename_table.sv
source/free_list.sv
source/rob.sv
source/rename_top.sv
bench/rename_tb.sv

//--- Bender.yml
package:
  name: rename_top

sources:
  - source/cpu_pkg.sv
  - source/id_itf.sv
  - source/decoder.sv
  - source/id_stage.sv
  - source/rename_table.sv
  - source/free_list.sv
  - source/rob.sv
  - source/rename_top.sv
  - target: simulation
    files:
      - bench/rename_tb.sv

//--- bench/rename_tb.sv
`timescale 1ns/10ps

module rename_tb;

    localparam int N_RAND         = 150;
    localparam int NUM_BUNDLES    = 11 + N_RAND;
    localparam int TIMEOUT_CYCLES = 4 * NUM_BUNDLES + 200;

    typedef cpu_pkg::uop_t [cpu_pkg::ID_WIDTH-1:0] bundle_t;

    typedef struct packed {
        logic [cpu_pkg::ARF_IDX-1:0] rd_arch;
        logic [cpu_pkg::PRF_IDX-1:0] rd_phy;
        logic [cpu_pkg::PRF_IDX-1:0] old_phy;
    } rob_entry_t;

    logic                               clk;
    logic                               rst_n;
    logic                               in_valid;
    logic                               in_ready;
    logic [31:0]                        in_pc;
    logic [cpu_pkg::ID_WIDTH-1:0][31:0] in_inst;
    logic [cpu_pkg::ID_WIDTH-1:0]       in_slot_valid;
    logic                               out_valid;
    logic                               out_ready;
    cpu_pkg::uop_t                      out_uops [cpu_pkg::ID_WIDTH];
    logic                               retire_valid;
    logic                               retire_ready;
    logic [cpu_pkg::ARF_IDX-1:0]        retire_rd_arch;
    logic [cpu_pkg::PRF_IDX-1:0]        retire_rd_phy;

    // Reference rename state
    logic [cpu_pkg::PRF_IDX-1:0] map_ref [32];
    logic [cpu_pkg::PRF_IDX-1:0] free_q [$];
    rob_entry_t                  rob_q [$];
    logic [cpu_pkg::ROB_IDX-1:0] rob_tail_ref;

    logic [31:0] rng = 32'd23;
    logic        rand_ports;
    int          cycle_count;
    cpu_pkg::opcode_t op_list [9] = '{cpu_pkg::LUI, cpu_pkg::AUIPC, cpu_pkg::JAL,
        cpu_pkg::JALR, cpu_pkg::BRANCH, cpu_pkg::LOAD, cpu_pkg::STORE, cpu_pkg::OP_IMM,
        cpu_pkg::OP};

    rename_top i_dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    function automatic void check_value(input string name, input logic [31:0] exp_val,
                                        input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("Fail %s expected %h actual %h", name, exp_val, act_val);
            $display("TB FAILED");
            $fatal(1);
        end
    endfunction

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Registers x0 to x7 only so that slots often depend on each other
    function automatic logic [31:0] random_inst();
        logic [31:0] r;
        r = next_rand();
        return {r[31:25], 2'b0, r[22:20], 2'b0, r[17:15], r[14:12], 2'b0, r[9:7],
                op_list[r[3:0] % 9]};
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic cpu_pkg::uop_t decode_ref(input logic [31:0] inst);
        cpu_pkg::uop_t u;
        logic [2:0]    funct3;
        logic [31:0]   imm_i;
        logic [31:0]   imm_s;
        logic [31:0]   imm_b;
        logic [31:0]   imm_u;
        logic [31:0]   imm_j;
        logic          reads_rs1;
        logic          reads_rs2;
        logic          writes_rd;
        funct3 = inst[14:12];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = inst & 32'hffff_f000;
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        u = '0;
        u.inst    = inst;
        u.fu_type = cpu_pkg::FU_ALU;
        u.op1_sel = cpu_pkg::OP1_RS1;
        u.op2_sel = cpu_pkg::OP2_IMM;
        u.imm     = imm_i;
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b0;
        writes_rd = 1'b1;
        case (inst[6:0])
            cpu_pkg::LUI: begin
                u.op1_sel = cpu_pkg::OP1_ZERO;
                u.imm     = imm_u;
                reads_rs1 = 1'b0;
            end
            cpu_pkg::AUIPC: begin
                u.op1_sel = cpu_pkg::OP1_PC;
                u.imm     = imm_u;
                reads_rs1 = 1'b0;
            end
            cpu_pkg::JAL: begin
                u.fu_type = cpu_pkg::FU_BR;
                u.op1_sel = cpu_pkg::OP1_PC;
                u.imm     = imm_j;
                reads_rs1 = 1'b0;
            end
            cpu_pkg::JALR: u.fu_type = cpu_pkg::FU_BR;
            cpu_pkg::BRANCH: begin
                u.fu_type   = cpu_pkg::FU_BR;
                u.fu_opcode = {1'b0, funct3};
                u.op2_sel   = cpu_pkg::OP2_RS2;
                u.imm       = imm_b;
                reads_rs2   = 1'b1;
                writes_rd   = 1'b0;
            end
            cpu_pkg::LOAD: begin
                u.fu_type   = cpu_pkg::FU_MEM;
                u.fu_opcode = {1'b0, funct3};
            end
            cpu_pkg::STORE: begin
                u.fu_type   = cpu_pkg::FU_MEM;
                u.fu_opcode = {1'b0, funct3};
                u.imm       = imm_s;
                reads_rs2   = 1'b1;
                writes_rd   = 1'b0;
            end
            cpu_pkg::OP_IMM: begin
                u.fu_type = cpu_pkg::FU_ALU;
                // srai is the only immediate op told apart by funct7
                if (funct3 == 3'b101) begin
                    u.fu_opcode = {inst[30], funct3};
                end else begin
                    u.fu_opcode = {1'b0, funct3};
                end
            end
            cpu_pkg::OP: begin
                u.fu_opcode = {inst[30], funct3};
                u.op2_sel   = cpu_pkg::OP2_RS2;
                u.imm       = '0;
                reads_rs2   = 1'b1;
            end
            default: begin
                u.op1_sel = cpu_pkg::OP1_ZERO;
                u.imm     = '0;
                reads_rs1 = 1'b0;
                writes_rd = 1'b0;
            end
        endcase
        u.rd_arch  = writes_rd ? inst[11:7] : '0;
        u.rs1_arch = reads_rs1 ? inst[19:15] : '0;
        u.rs2_arch = reads_rs2 ? inst[24:20] : '0;
        return u;
    endfunction

    // Slots rename in order and slot 1 already sees slot 0's new mapping
    function automatic bundle_t predict_bundle(input logic [31:0] pc,
                                               input logic [cpu_pkg::ID_WIDTH-1:0][31:0] insts,
                                               input logic [cpu_pkg::ID_WIDTH-1:0] slot_valid);
        bundle_t    exp;
        rob_entry_t ent;
        for (int i = 0; i < cpu_pkg::ID_WIDTH; i++) begin
            exp[i]       = decode_ref(insts[i]);
            exp[i].valid = slot_valid[i];
            exp[i].pc    = pc + 32'(4 * i);
            if (slot_valid[i]) begin
                exp[i].rs1_phy = map_ref[exp[i].rs1_arch];
                exp[i].rs2_phy = map_ref[exp[i].rs2_arch];
                ent.rd_arch    = exp[i].rd_arch;
                ent.old_phy    = map_ref[exp[i].rd_arch];
                if (exp[i].rd_arch != '0) begin
                    exp[i].rd_phy           = free_q.pop_front();
                    map_ref[exp[i].rd_arch] = exp[i].rd_phy;
                end
                ent.rd_phy    = exp[i].rd_phy;
                exp[i].rob_id = rob_tail_ref;
                rob_tail_ref  = rob_tail_ref + 1'b1;
                rob_q.push_back(ent);
            end
        end
        return exp;
    endfunction

    function automatic rob_entry_t predict_retire();
        rob_entry_t head;
        head = rob_q.pop_front();
        if (head.rd_arch != '0) begin
            free_q.push_back(head.old_phy);
        end
        return head;
    endfunction

    ////////////////////////////////////////////////////////////
    // Comparator on the falling clock edge
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin : compare
        bundle_t    exp;
        rob_entry_t head;
        logic       room;
        if (rst_n) begin
            room = (free_q.size() >= cpu_pkg::ID_WIDTH)
                && (rob_q.size() <= cpu_pkg::ROB_SIZE - cpu_pkg::ID_WIDTH);
            check_value("retire_valid", rob_q.size() != 0, retire_valid);
            check_value("in_ready", room && out_ready, in_ready);
            check_value("out_valid", room && in_valid, out_valid);
            if (in_valid && in_ready) begin
                exp = predict_bundle(in_pc, in_inst, in_slot_valid);
                for (int i = 0; i < cpu_pkg::ID_WIDTH; i++) begin
                    check_value("valid", exp[i].valid, out_uops[i].valid);
                    if (exp[i].valid) begin
                        check_value("pc", exp[i].pc, out_uops[i].pc);
                        check_value("inst", exp[i].inst, out_uops[i].inst);
                        check_value("fu_type", exp[i].fu_type, out_uops[i].fu_type);
                        check_value("fu_opcode", exp[i].fu_opcode, out_uops[i].fu_opcode);
                        check_value("op1_sel", exp[i].op1_sel, out_uops[i].op1_sel);
                        check_value("op2_sel", exp[i].op2_sel, out_uops[i].op2_sel);
                        check_value("imm", exp[i].imm, out_uops[i].imm);
                        check_value("rd_arch", exp[i].rd_arch, out_uops[i].rd_arch);
                        check_value("rs1_arch", exp[i].rs1_arch, out_uops[i].rs1_arch);
                        check_value("rs2_arch", exp[i].rs2_arch, out_uops[i].rs2_arch);
                        check_value("rd_phy", exp[i].rd_phy, out_uops[i].rd_phy);
                        check_value("rs1_phy", exp[i].rs1_phy, out_uops[i].rs1_phy);
                        check_value("rs2_phy", exp[i].rs2_phy, out_uops[i].rs2_phy);
                        check_value("rob_id", exp[i].rob_id, out_uops[i].rob_id);
                    end
                end
            end
            if (retire_valid && retire_ready) begin
                head = predict_retire();
                check_value("retire_rd_arch", head.rd_arch, retire_rd_arch);
                check_value("retire_rd_phy", head.rd_phy, retire_rd_phy);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic drive_bundle(input logic [31:0] i0, input logic [31:0] i1,
                                input logic [1:0] sv);
        in_valid      = 1'b1;
        in_inst[0]    = i0;
        in_inst[1]    = i1;
        in_slot_valid = sv;
    endtask

    task automatic wait_fire();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = in_valid && in_ready;
            @(posedge clk);
            #2;
            if (rand_ports) begin
                retire_ready = (next_rand() % 8) != 0;
                out_ready    = (next_rand() % 16) != 0;
            end
        end
        in_valid = 1'b0;
        in_pc    = in_pc + 32'd8;
    endtask

    task automatic send_bundle(input logic [31:0] i0, input logic [31:0] i1,
                               input logic [1:0] sv);
        drive_bundle(i0, i1, sv);
        wait_fire();
    endtask

    initial begin
        logic [31:0] r;
        clk           = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_pc         = 32'h0000_1000;
        in_inst       = '0;
        in_slot_valid = '0;
        out_ready     = 1'b1;
        retire_ready  = 1'b0;
        rand_ports    = 1'b0;
        cycle_count   = 0;
        rob_tail_ref  = '0;
        for (int r_i = 0; r_i < 32; r_i++) begin
            map_ref[r_i] = (cpu_pkg::PRF_IDX)'(r_i);
        end
        for (int p = 32; p < cpu_pkg::PRF_SIZE; p++) begin
            free_q.push_back((cpu_pkg::PRF_IDX)'(p));
        end
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // addi x1, x2, 5 then add x3, x1, x1 on the identity map
        send_bundle(32'h0051_0093, 32'h0010_81b3, 2'b11);
        // lui x5 with slot 1 empty, then sw x3, 8(x1) alone in slot 1
        send_bundle(32'h1234_52b7, 32'h0051_0093, 2'b01);
        send_bundle(32'h0051_0093, 32'h0030_a423, 2'b10);

        // Fill the ROB with retire held off, then stall on it
        repeat (6) send_bundle(random_inst(), random_inst(), 2'b11);
        drive_bundle(random_inst(), random_inst(), 2'b11);
        repeat (8) begin
            @(negedge clk);
            check_value("in_ready", 1'b0, in_ready);
            @(posedge clk);
            #2;
        end
        retire_ready = 1'b1;
        wait_fire();

        // Stall from dispatch
        out_ready = 1'b0;
        drive_bundle(random_inst(), random_inst(), 2'b11);
        repeat (5) begin
            @(negedge clk);
            check_value("in_ready", 1'b0, in_ready);
            @(posedge clk);
            #2;
        end
        out_ready = 1'b1;
        wait_fire();

        // Random traffic with random retire and dispatch stalls
        rand_ports = 1'b1;
        for (int n = 0; n < N_RAND; n++) begin
            r = next_rand();
            if (r[2:0] == 3'd0) begin
                @(posedge clk);
                #2;
            end
            send_bundle(random_inst(), random_inst(),
                        (r[5:4] == 2'd0) ? {r[6], ~r[6]} : 2'b11);
        end

        // Drain the ROB
        rand_ports   = 1'b0;
        retire_ready = 1'b1;
        out_ready    = 1'b1;
        do begin
            @(negedge clk);
        end while (retire_valid);
        @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- source/rename_top.sv
`timescale 1ns/10ps

module rename_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  logic [31:0]                        in_pc,
    input  logic [cpu_pkg::ID_WIDTH-1:0][31:0] in_inst,
    input  logic [cpu_pkg::ID_WIDTH-1:0]       in_slot_valid,
    output logic                               out_valid,
    input  logic                               out_ready,
    output cpu_pkg::uop_t                      out_uops [cpu_pkg::ID_WIDTH],
    output logic                               retire_valid,
    input  logic                               retire_ready,
    output logic [cpu_pkg::ARF_IDX-1:0]        retire_rd_arch,
    output logic [cpu_pkg::PRF_IDX-1:0]        retire_rd_phy
);
    rat_itf rat_if ();
    fl_itf  fl_if ();
    rob_itf rob_if ();

    id_stage u_id_stage (
        .clk           (clk),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_pc         (in_pc),
        .in_inst       (in_inst),
        .in_slot_valid (in_slot_valid),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .uops          (out_uops),
        .to_rat        (rat_if.id),
        .to_fl         (fl_if.id),
        .to_rob        (rob_if.id)
    );

    rename_table u_rename_table (
        .clk   (clk),
        .rst_n (rst_n),
        .rat   (rat_if.tbl)
    );

    free_list u_free_list (
        .clk   (clk),
        .rst_n (rst_n),
        .fl    (fl_if.list)
    );

    // Retired old registers go straight back to the free list
    rob u_rob (
        .clk            (clk),
        .rst_n          (rst_n),
        .alloc          (rob_if.rob),
        .retire_valid   (retire_valid),
        .retire_ready   (retire_ready),
        .retire_rd_arch (retire_rd_arch),
        .retire_rd_phy  (retire_rd_phy),
        .free_push      (fl_if.push),
        .free_idx       (fl_if.push_idx)
    );

endmodule

//--- source/rob.sv
`timescale 1ns/10ps

module rob (
    input  logic                        clk,
    input  logic                        rst_n,
    rob_itf.rob                         alloc,
    output logic                        retire_valid,
    input  logic                        retire_ready,
    output logic [cpu_pkg::ARF_IDX-1:0] retire_rd_arch,
    output logic [cpu_pkg::PRF_IDX-1:0] retire_rd_phy,
    output logic                        free_push,
    output logic [cpu_pkg::PRF_IDX-1:0] free_idx
);
    logic [cpu_pkg::ARF_IDX-1:0] rd_arch_q [cpu_pkg::ROB_SIZE];
    logic [cpu_pkg::PRF_IDX-1:0] rd_phy_q [cpu_pkg::ROB_SIZE];
    logic [cpu_pkg::PRF_IDX-1:0] old_phy_q [cpu_pkg::ROB_SIZE];
    logic [cpu_pkg::ROB_IDX-1:0] head;
    logic [cpu_pkg::ROB_IDX-1:0] tail;
    logic [cpu_pkg::ROB_IDX:0]   count;
    logic [cpu_pkg::ROB_IDX-1:0] n_valid;
    logic                        retire;

    // Valid slots get consecutive entries, invalid ones are skipped
    always_comb begin
        n_valid = '0;
        for (int i = 0; i < cpu_pkg::ID_WIDTH; i++) begin
            alloc.rob_id[i] = tail + n_valid;
            if (alloc.inst_valid[i]) begin
                n_valid = n_valid + 1'b1;
            end
        end
    end

    assign alloc.ready = count <= (cpu_pkg::ROB_IDX+1)'(cpu_pkg::ROB_SIZE - cpu_pkg::ID_WIDTH);

    ////////////////////////////////////////////////////////////
    // Retire from the head
    ////////////////////////////////////////////////////////////

    assign retire_valid   = count != '0;
    assign retire         = retire_valid && retire_ready;
    assign retire_rd_arch = rd_arch_q[head];
    assign retire_rd_phy  = rd_phy_q[head];
    assign free_push      = retire && (rd_arch_q[head] != '0);
    assign free_idx       = old_phy_q[head];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc.alloc) begin
                tail <= tail + n_valid;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + (alloc.alloc ? (cpu_pkg::ROB_IDX+1)'(n_valid) : '0)
                     - (cpu_pkg::ROB_IDX+1)'(retire);
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < cpu_pkg::ID_WIDTH; i++) begin
            if (alloc.alloc && alloc.inst_valid[i]) begin
                rd_arch_q[alloc.rob_id[i]] <= alloc.rd_arch[i];
                rd_phy_q[alloc.rob_id[i]]  <= alloc.rd_phy[i];
                old_phy_q[alloc.rob_id[i]] <= alloc.old_phy[i];
            end
        end
    end

endmodule

//--- source/free_list.sv
`timescale 1ns/10ps

module free_list (
    input  logic clk,
    input  logic rst_n,
    fl_itf.list  fl
);
    logic [cpu_pkg::PRF_IDX-1:0] slots [cpu_pkg::PRF_SIZE];
    logic [cpu_pkg::PRF_IDX-1:0] head;
    logic [cpu_pkg::PRF_IDX-1:0] tail;
    logic [cpu_pkg::PRF_IDX:0]   count;
    logic [cpu_pkg::PRF_IDX-1:0] n_pop;

    // Each slot takes the entry past those taken by older slots
    always_comb begin
        n_pop = '0;
        for (int i = 0; i < cpu_pkg::ID_WIDTH; i++) begin
            fl.free_idx[i] = slots[head + n_pop];
            if (fl.pop[i]) begin
                n_pop = n_pop + 1'b1;
            end
        end
    end

    assign fl.ready = count >= (cpu_pkg::PRF_IDX+1)'(cpu_pkg::ID_WIDTH);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= (cpu_pkg::PRF_IDX)'(cpu_pkg::FREE_INIT);
            count <= (cpu_pkg::PRF_IDX+1)'(cpu_pkg::FREE_INIT);
            // Registers above the identity map start out free
            for (int i = 0; i < cpu_pkg::FREE_INIT; i++) begin
                slots[i] <= (cpu_pkg::PRF_IDX)'(cpu_pkg::FREE_INIT + i);
            end
        end else begin
            head  <= head + n_pop;
            count <= count - (cpu_pkg::PRF_IDX+1)'(n_pop) + (cpu_pkg::PRF_IDX+1)'(fl.push);
            if (fl.push) begin
                slots[tail] <= fl.push_idx;
                tail        <= tail + 1'b1;
            end
        end
    end

endmodule

//--- source/rename_table.sv
`timescale 1ns/10ps

module rename_table (
    input  logic clk,
    input  logic rst_n,
    rat_itf.tbl  rat
);
    logic [cpu_pkg::PRF_IDX-1:0] map [2**cpu_pkg::ARF_IDX];

    // Read ports, old_phy is the mapping about to be replaced
    always_comb begin
        for (int i = 0; i < cpu_pkg::ID_WIDTH; i++) begin
            rat.rs1_phy[i] = map[rat.rs1_arch[i]];
            rat.rs2_phy[i] = map[rat.rs2_arch[i]];
            rat.old_phy[i] = map[rat.rd_arch[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 2**cpu_pkg::ARF_IDX; r++) begin
                map[r] <= (cpu_pkg::PRF_IDX)'(r);
            end
        end else begin
            // Later slot overrides an earlier one on the same rd
            for (int i = 0; i < cpu_pkg::ID_WIDTH; i++) begin
                if (rat.write_en[i] && (rat.rd_arch[i] != '0)) begin
                    map[rat.rd_arch[i]] <= rat.rd_phy[i];
                end
            end
        end
    end

endmodule

//--- source/id_stage.sv
`timescale 1ns/10ps

module id_stage (
    input  logic                               clk,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  logic [31:0]                        in_pc,
    input  logic [cpu_pkg::ID_WIDTH-1:0][31:0] in_inst,
    input  logic [cpu_pkg::ID_WIDTH-1:0]       in_slot_valid,
    output logic                               out_valid,
    input  logic                               out_ready,
    output cpu_pkg::uop_t                      uops [cpu_pkg::ID_WIDTH],
    rat_itf.id                                 to_rat,
    fl_itf.id                                  to_fl,
    rob_itf.id                                 to_rob
);
    cpu_pkg::uop_t                                      dec [cpu_pkg::ID_WIDTH];
    logic                                               fire;
    logic [cpu_pkg::ID_WIDTH-1:0]                       has_rd;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::PRF_IDX-1:0] new_phy;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::PRF_IDX-1:0] rs1_phy;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::PRF_IDX-1:0] rs2_phy;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::PRF_IDX-1:0] old_phy;

    ////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////

    assign in_ready     = to_fl.ready && to_rob.ready && out_ready;
    assign out_valid    = in_valid && to_fl.ready && to_rob.ready;
    assign fire         = in_valid && in_ready;
    assign to_rob.alloc = fire;

    ////////////////////////////////////////////////////////////
    // Decode and per-slot rename requests
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < cpu_pkg::ID_WIDTH; i++) begin : g_slot
        decoder u_decoder (
            .inst      (in_inst[i]),
            .rs_fields (dec[i])
        );

        assign has_rd[i]  = in_slot_valid[i] && (dec[i].rd_arch != '0);
        assign new_phy[i] = has_rd[i] ? to_fl.free_idx[i] : '0;

        assign to_rat.rs1_arch[i] = dec[i].rs1_arch;
        assign to_rat.rs2_arch[i] = dec[i].rs2_arch;
        assign to_rat.rd_arch[i]  = dec[i].rd_arch;
        assign to_rat.write_en[i] = fire && has_rd[i];
        assign to_rat.rd_phy[i]   = to_fl.free_idx[i];

        // Only slots with a real destination consume a register
        assign to_fl.pop[i] = fire && has_rd[i];

        assign to_rob.inst_valid[i] = in_slot_valid[i];
        assign to_rob.rd_arch[i]    = dec[i].rd_arch;
        assign to_rob.rd_phy[i]     = new_phy[i];
        assign to_rob.old_phy[i]    = old_phy[i];
    end

    ////////////////////////////////////////////////////////////
    // Bypass inside the bundle and uop assembly
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < cpu_pkg::ID_WIDTH; i++) begin
            rs1_phy[i] = to_rat.rs1_phy[i];
            rs2_phy[i] = to_rat.rs2_phy[i];
            old_phy[i] = to_rat.old_phy[i];
            // Nearest older writer wins
            for (int j = 0; j < i; j++) begin
                if (has_rd[j] && (dec[j].rd_arch == dec[i].rs1_arch)) begin
                    rs1_phy[i] = new_phy[j];
                end
                if (has_rd[j] && (dec[j].rd_arch == dec[i].rs2_arch)) begin
                    rs2_phy[i] = new_phy[j];
                end
                if (has_rd[j] && (dec[j].rd_arch == dec[i].rd_arch)) begin
                    old_phy[i] = new_phy[j];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < cpu_pkg::ID_WIDTH; i++) begin
            uops[i]         = dec[i];
            uops[i].valid   = in_slot_valid[i];
            uops[i].pc      = in_pc + 32'(4 * i);
            uops[i].rd_phy  = new_phy[i];
            uops[i].rs1_phy = rs1_phy[i];
            uops[i].rs2_phy = rs2_phy[i];
            uops[i].rob_id  = to_rob.rob_id[i];
        end
    end

endmodule

//--- source/decoder.sv
`timescale 1ns/10ps

module decoder (
    input  logic [31:0]   inst,
    output cpu_pkg::uop_t rs_fields
);
    logic [2:0]  funct3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign funct3 = inst[14:12];
    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u  = {inst[31:12], 12'b0};
    assign imm_j  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        // Default is an ALU no-op: 0 + 0 into x0
        rs_fields         = '0;
        rs_fields.inst    = inst;
        rs_fields.fu_type = cpu_pkg::FU_ALU;
        rs_fields.op1_sel = cpu_pkg::OP1_ZERO;
        rs_fields.op2_sel = cpu_pkg::OP2_IMM;
        case (cpu_pkg::opcode_t'(inst[6:0]))
            cpu_pkg::LUI: begin
                rs_fields.imm     = imm_u;
                rs_fields.rd_arch = inst[11:7];
            end
            cpu_pkg::AUIPC: begin
                rs_fields.op1_sel = cpu_pkg::OP1_PC;
                rs_fields.imm     = imm_u;
                rs_fields.rd_arch = inst[11:7];
            end
            cpu_pkg::JAL: begin
                rs_fields.fu_type = cpu_pkg::FU_BR;
                rs_fields.op1_sel = cpu_pkg::OP1_PC;
                rs_fields.imm     = imm_j;
                rs_fields.rd_arch = inst[11:7];
            end
            cpu_pkg::JALR: begin
                rs_fields.fu_type  = cpu_pkg::FU_BR;
                rs_fields.op1_sel  = cpu_pkg::OP1_RS1;
                rs_fields.imm      = imm_i;
                rs_fields.rd_arch  = inst[11:7];
                rs_fields.rs1_arch = inst[19:15];
            end
            // No destination for branches and stores
            cpu_pkg::BRANCH: begin
                rs_fields.fu_type   = cpu_pkg::FU_BR;
                rs_fields.fu_opcode = {1'b0, funct3};
                rs_fields.op1_sel   = cpu_pkg::OP1_RS1;
                rs_fields.op2_sel   = cpu_pkg::OP2_RS2;
                rs_fields.imm       = imm_b;
                rs_fields.rs1_arch  = inst[19:15];
                rs_fields.rs2_arch  = inst[24:20];
            end
            cpu_pkg::LOAD: begin
                rs_fields.fu_type   = cpu_pkg::FU_MEM;
                rs_fields.fu_opcode = {1'b0, funct3};
                rs_fields.op1_sel   = cpu_pkg::OP1_RS1;
                rs_fields.imm       = imm_i;
                rs_fields.rd_arch   = inst[11:7];
                rs_fields.rs1_arch  = inst[19:15];
            end
            cpu_pkg::STORE: begin
                rs_fields.fu_type   = cpu_pkg::FU_MEM;
                rs_fields.fu_opcode = {1'b0, funct3};
                rs_fields.op1_sel   = cpu_pkg::OP1_RS1;
                rs_fields.imm       = imm_s;
                rs_fields.rs1_arch  = inst[19:15];
                rs_fields.rs2_arch  = inst[24:20];
            end
            cpu_pkg::OP_IMM: begin
                // Bit 30 only matters for srai
                rs_fields.fu_opcode = {(funct3 == 3'b101) && inst[30], funct3};
                rs_fields.op1_sel   = cpu_pkg::OP1_RS1;
                rs_fields.imm       = imm_i;
                rs_fields.rd_arch   = inst[11:7];
                rs_fields.rs1_arch  = inst[19:15];
            end
            cpu_pkg::OP: begin
                rs_fields.fu_opcode = {inst[30], funct3};
                rs_fields.op1_sel   = cpu_pkg::OP1_RS1;
                rs_fields.op2_sel   = cpu_pkg::OP2_RS2;
                rs_fields.rd_arch   = inst[11:7];
                rs_fields.rs1_arch  = inst[19:15];
                rs_fields.rs2_arch  = inst[24:20];
            end
            default: begin
            end
        endcase
    end

endmodule

//--- source/id_itf.sv
`timescale 1ns/10ps

// Rename table lookups and bundle writes
interface rat_itf;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::ARF_IDX-1:0] rs1_arch;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::ARF_IDX-1:0] rs2_arch;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::ARF_IDX-1:0] rd_arch;
    logic [cpu_pkg::ID_WIDTH-1:0]                       write_en;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::PRF_IDX-1:0] rd_phy;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::PRF_IDX-1:0] rs1_phy;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::PRF_IDX-1:0] rs2_phy;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::PRF_IDX-1:0] old_phy;

    modport id  (output rs1_arch, rs2_arch, rd_arch, write_en, rd_phy,
                 input  rs1_phy, rs2_phy, old_phy);
    modport tbl (input  rs1_arch, rs2_arch, rd_arch, write_en, rd_phy,
                 output rs1_phy, rs2_phy, old_phy);
endinterface

// Free list pops per slot, one push per cycle from retire
interface fl_itf;
    logic [cpu_pkg::ID_WIDTH-1:0]                       pop;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::PRF_IDX-1:0] free_idx;
    logic                                               ready;
    logic                                               push;
    logic [cpu_pkg::PRF_IDX-1:0]                        push_idx;

    modport id   (output pop, input free_idx, ready);
    modport list (input pop, push, push_idx, output free_idx, ready);
endinterface

// ROB allocation
interface rob_itf;
    logic                                               alloc;
    logic [cpu_pkg::ID_WIDTH-1:0]                       inst_valid;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::ARF_IDX-1:0] rd_arch;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::PRF_IDX-1:0] rd_phy;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::PRF_IDX-1:0] old_phy;
    logic                                               ready;
    logic [cpu_pkg::ID_WIDTH-1:0][cpu_pkg::ROB_IDX-1:0] rob_id;

    modport id  (output alloc, inst_valid, rd_arch, rd_phy, old_phy, input ready, rob_id);
    modport rob (input alloc, inst_valid, rd_arch, rd_phy, old_phy, output ready, rob_id);
endinterface

//--- source/cpu_pkg.sv
package cpu_pkg;

    // Machine sizes
    localparam int ID_WIDTH  = 2;
    localparam int ARF_IDX   = 5;
    localparam int PRF_SIZE  = 64;
    localparam int PRF_IDX   = 6;
    localparam int ROB_SIZE  = 16;
    localparam int ROB_IDX   = 4;
    localparam int FREE_INIT = PRF_SIZE - 32;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_t;

    typedef enum logic [1:0] {FU_ALU, FU_BR, FU_MEM} fu_type_t;
    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_t;
    typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_t;

    typedef struct packed {
        logic                valid;
        logic [31:0]         pc;
        logic [31:0]         inst;
        fu_type_t            fu_type;
        logic [3:0]          fu_opcode;
        op1_sel_t            op1_sel;
        op2_sel_t            op2_sel;
        logic [31:0]         imm;
        logic [ARF_IDX-1:0]  rd_arch;
        logic [ARF_IDX-1:0]  rs1_arch;
        logic [ARF_IDX-1:0]  rs2_arch;
        logic [PRF_IDX-1:0]  rd_phy;
        logic [PRF_IDX-1:0]  rs1_phy;
        logic [PRF_IDX-1:0]  rs2_phy;
        logic [ROB_IDX-1:0]  rob_id;
    } uop_t;

endpackage
